// File: Makefile
VERILATOR  ?= verilator
TOP        ?= blur_tb
FILELIST   ?= sim.f
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   := Verification failed
PASS_MSG   := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a verdict, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/blur_tb.sv
`timescale 1ns/1ps
`include "blur_defs.svh"

module blur_tb;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int SEED            = 48024;
    localparam int NUM_FRAMES      = 4;
    localparam int MARGIN_CYCLES   = 2000;  // Reset, idle and readback time
    localparam int WATCHDOG_CYCLES = `HRES * `VRES * NUM_FRAMES * 4 + MARGIN_CYCLES;
    localparam int SCALE           = 1 << `SCALE_SHIFT;

    localparam int MODE_UNIFORM   = 0;
    localparam int MODE_RANDOM    = 1;
    localparam int MODE_GAPS      = 2;
    localparam int MODE_OFF_FRAME = 3;

    typedef blur_pkg::rgb565_t [`HRES-1:0] row_t;

    logic               clk_pixel;
    logic               recent_reset;
    logic               pixel_valid_i;
    logic               pixel_ready_o;
    logic [15:0]        pixel_data_i;
    logic [10:0]        hcount_i;
    logic [9:0]         vcount_i;
    blur_pkg::fb_addr_t rd_addr_i;
    logic [15:0]        rd_data_o;
    logic               frame_done_o;

    blur_pkg::rgb565_t frame_pix [`VRES][`HRES];
    blur_pkg::rgb565_t exp_fb [`FB_DEPTH];  // Expected buffer for the frame in flight
    string             cur_test;
    int                errors = 0;
    int                checks = 0;
    int                frames_sent = 0;
    int                readbacks = 0;
    int                done_cycles = 0;

    blur_top blur_top_i (
        .clk_pixel     (clk_pixel),
        .recent_reset  (recent_reset),
        .pixel_valid_i (pixel_valid_i),
        .pixel_ready_o (pixel_ready_o),
        .pixel_data_i  (pixel_data_i),
        .hcount_i      (hcount_i),
        .vcount_i      (vcount_i),
        .rd_addr_i     (rd_addr_i),
        .rd_data_o     (rd_data_o),
        .frame_done_o  (frame_done_o)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pixel = ~clk_pixel;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Horizontal causal 1-2-1 blur, applied once per chained stage
    function automatic row_t blur_ref(input row_t row);
        row_t              cur;
        row_t              nxt;
        blur_pkg::rgb565_t e;
        blur_pkg::rgb565_t l;
        cur = row;
        for (int p = 0; p < `NUM_BLUR; p++) begin
            for (int x = 0; x < `HRES; x++) begin
                if (x == 0) begin
                    e = cur[x];  // Row start sees itself as both neighbours
                    l = cur[x];
                end
                nxt[x].red   = 5'((int'(e.red) + 2 * int'(l.red) + int'(cur[x].red)) / 4);
                nxt[x].green = 6'((int'(e.green) + 2 * int'(l.green) + int'(cur[x].green)) / 4);
                nxt[x].blue  = 5'((int'(e.blue) + 2 * int'(l.blue) + int'(cur[x].blue)) / 4);
                e = l;
                l = cur[x];
            end
            cur = nxt;
        end
        return cur;
    endfunction

    // Blur every row, then keep one pixel per SCALE x SCALE block
    task automatic build_expected();
        row_t row;
        row_t blurred;
        int   addr;
        for (int y = 0; y < `VRES; y += SCALE) begin
            for (int x = 0; x < `HRES; x++) begin
                row[x] = frame_pix[y][x];
            end
            blurred = blur_ref(row);
            for (int x = 0; x < `HRES; x += SCALE) begin
                addr = (x >> `SCALE_SHIFT) + `FB_WIDTH * (y >> `SCALE_SHIFT);
                exp_fb[addr] = blurred[x];
            end
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk_pixel);
        pixel_valid_i = 1'b0;
    endtask

    task automatic send_beat(input logic [15:0] pix, input logic [10:0] h,
                             input logic [9:0] v);
        @(negedge clk_pixel);
        pixel_valid_i = 1'b1;
        pixel_data_i  = pix;
        hcount_i      = h;
        vcount_i      = v;
        #1;
        check_value({cur_test, " ready while valid"}, 32'd1, {31'd0, pixel_ready_o});
        while (!pixel_ready_o) begin  // Hold the beat until it is taken
            @(negedge clk_pixel);
            #1;
        end
    endtask

    task automatic send_off_frame();
        logic [10:0] h;
        logic [9:0]  v;
        if ($urandom_range(0, 1) == 0) begin
            h = 11'($urandom_range(2047, `HRES));
            v = 10'($urandom_range(1023, 0));
        end else begin
            h = 11'($urandom_range(`HRES - 1, 0));
            v = 10'($urandom_range(1023, `VRES));
        end
        send_beat(16'($urandom), h, v);
    endtask

    task automatic run_frame(input string name, input int mode);
        blur_pkg::rgb565_t colour;
        colour = 16'($urandom);
        for (int y = 0; y < `VRES; y++) begin
            for (int x = 0; x < `HRES; x++) begin
                if (mode == MODE_UNIFORM) begin
                    frame_pix[y][x] = colour;
                end else begin
                    frame_pix[y][x] = 16'($urandom);
                end
            end
        end
        if (mode == MODE_UNIFORM) begin
            for (int a = 0; a < `FB_DEPTH; a++) begin
                exp_fb[a] = colour;  // A flat field stays flat through the blur
            end
        end else begin
            build_expected();
        end
        cur_test = name;
        for (int y = 0; y < `VRES; y++) begin
            for (int x = 0; x < `HRES; x++) begin
                if (mode == MODE_GAPS) begin
                    while ($urandom_range(2, 0) == 0) idle_cycle();
                end
                if (mode == MODE_OFF_FRAME && $urandom_range(3, 0) == 0) begin
                    send_off_frame();
                end
                send_beat(frame_pix[y][x], 11'(x), 10'(y));
            end
        end
        idle_cycle();
        frames_sent++;
        wait (readbacks == frames_sent);
        check_value({name, " done pulses"}, 32'(frames_sent), 32'(done_cycles));
    endtask

    task automatic read_frame();
        for (int a = 0; a < `FB_DEPTH; a++) begin
            rd_addr_i = blur_pkg::fb_addr_t'(a);
            @(negedge clk_pixel);  // One cycle of read latency
            check_value($sformatf("%s addr %0d", cur_test, a),
                        {16'd0, 16'(exp_fb[a])}, {16'd0, rd_data_o});
        end
    endtask

    // Readback and compare after every end-of-frame pulse
    initial begin
        rd_addr_i = '0;
        forever begin
            @(negedge clk_pixel);
            if (frame_done_o === 1'b1) begin
                read_frame();
                readbacks++;
            end
        end
    end

    always @(negedge clk_pixel) begin
        if (frame_done_o === 1'b1) begin
            done_cycles++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        recent_reset  = 1'b1;
        pixel_valid_i = 1'b0;
        pixel_data_i  = '0;
        hcount_i      = '0;
        vcount_i      = '0;
        cur_test      = "reset";
        repeat (RESET_CYCLES) begin
            @(negedge clk_pixel);
            check_value("reset done low", 32'd0, {31'd0, frame_done_o});
        end
        recent_reset = 1'b0;
        repeat (8) idle_cycle();
        check_value("idle done pulses", 32'd0, 32'(done_cycles));

        run_frame("uniform", MODE_UNIFORM);
        run_frame("random", MODE_RANDOM);
        run_frame("gaps", MODE_GAPS);
        run_frame("off_frame", MODE_OFF_FRAME);

        repeat (20) idle_cycle();
        check_value("total done pulses", 32'(NUM_FRAMES), 32'(done_cycles));
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: design/blur_defs.svh
`ifndef BLUR_DEFS_SVH
`define BLUR_DEFS_SVH

// Frame geometry of the incoming stream
`define HRES 64
`define VRES 16

// Downscale factor is 2**SCALE_SHIFT in each direction
`define SCALE_SHIFT 2

// Blur stages chained between intake and store
`define NUM_BLUR 3

// Stored frame after decimation
`define FB_WIDTH (`HRES >> `SCALE_SHIFT)
`define FB_DEPTH (`FB_WIDTH * (`VRES >> `SCALE_SHIFT))

// Coordinate widths, as delivered by the camera side
`define HCOUNT_W 11
`define VCOUNT_W 10

`endif

// File: design/blur_pkg.sv
package blur_pkg;

    `include "blur_defs.svh"

    // RGB565 pixel, red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    typedef logic [`HCOUNT_W-1:0] hcount_t;  // Column index
    typedef logic [`VCOUNT_W-1:0] vcount_t;  // Row index

    // Address into the decimated frame buffer
    localparam int FB_ADDR_W = $clog2(`FB_DEPTH);
    typedef logic [FB_ADDR_W-1:0] fb_addr_t;

endpackage

// File: design/blur_stage.sv
`timescale 1ns/1ps

module blur_stage (
    input  logic           clk_pixel,
    input  logic           recent_reset,
    pixel_stream_if.sink   in_i,
    pixel_stream_if.source out_o
);

    blur_pkg::rgb565_t hist_early;  // Two pixels back
    blur_pkg::rgb565_t hist_late;   // One pixel back
    blur_pkg::rgb565_t early;
    blur_pkg::rgb565_t late;
    logic              accept;
    logic              row_start;

    // 1-2-1 weighted sum per channel, truncated divide by four
    function automatic blur_pkg::rgb565_t kernel(
        input blur_pkg::rgb565_t e,
        input blur_pkg::rgb565_t l,
        input blur_pkg::rgb565_t c
    );
        logic [6:0] r_sum;
        logic [7:0] g_sum;
        logic [6:0] b_sum;
        blur_pkg::rgb565_t res;
        r_sum = {2'b00, e.red} + {1'b0, l.red, 1'b0} + {2'b00, c.red};
        g_sum = {2'b00, e.green} + {1'b0, l.green, 1'b0} + {2'b00, c.green};
        b_sum = {2'b00, e.blue} + {1'b0, l.blue, 1'b0} + {2'b00, c.blue};
        res.red   = r_sum[6:2];
        res.green = g_sum[7:2];
        res.blue  = b_sum[6:2];
        return res;
    endfunction

    assign in_i.ready = !out_o.valid || out_o.ready;
    assign accept = in_i.valid && in_i.ready;
    assign row_start = (in_i.hcount == '0);

    // First pixel of a row stands in for its missing left neighbours
    assign early = row_start ? in_i.pixel : hist_early;
    assign late  = row_start ? in_i.pixel : hist_late;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            out_o.valid <= 1'b0;
        end else if (accept) begin
            out_o.valid <= 1'b1;
        end else if (out_o.ready) begin
            out_o.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (accept) begin
            out_o.pixel  <= kernel(early, late, in_i.pixel);
            out_o.hcount <= in_i.hcount;  // Coordinates ride along unchanged
            out_o.vcount <= in_i.vcount;
            hist_early   <= late;
            hist_late    <= in_i.pixel;
        end
    end

    // Output slot still holds the previous beat, so it gives the last hcount
    a_row_order: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        accept && !row_start |-> in_i.hcount == out_o.hcount + 1)
        else $error("blur stage saw a gap or reorder within a row");

endmodule

// File: design/blur_top.sv
`timescale 1ns/1ps
`include "blur_defs.svh"

module blur_top (
    input  logic               clk_pixel,
    input  logic               recent_reset,
    input  logic               pixel_valid_i,
    output logic               pixel_ready_o,
    input  logic [15:0]        pixel_data_i,
    input  logic [10:0]        hcount_i,
    input  logic [9:0]         vcount_i,
    input  blur_pkg::fb_addr_t rd_addr_i,
    output logic [15:0]        rd_data_o,
    output logic               frame_done_o
);

    // stream[0] leaves the intake, stream[NUM_BLUR] enters the store
    pixel_stream_if stream [`NUM_BLUR+1] ();

    frame_intake frame_intake_i (
        .clk_pixel     (clk_pixel),
        .recent_reset  (recent_reset),
        .pixel_valid_i (pixel_valid_i),
        .pixel_ready_o (pixel_ready_o),
        .pixel_data_i  (pixel_data_i),
        .hcount_i      (hcount_i),
        .vcount_i      (vcount_i),
        .out_o         (stream[0])
    );

    for (genvar k = 0; k < `NUM_BLUR; k++) begin : g_blur
        blur_stage blur_stage_i (
            .clk_pixel    (clk_pixel),
            .recent_reset (recent_reset),
            .in_i         (stream[k]),
            .out_o        (stream[k+1])
        );
    end

    downscale_store downscale_store_i (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .in_i         (stream[`NUM_BLUR]),
        .rd_addr_i    (rd_addr_i),
        .rd_data_o    (rd_data_o),
        .frame_done_o (frame_done_o)
    );

endmodule

// File: design/downscale_store.sv
`timescale 1ns/1ps
`include "blur_defs.svh"

module downscale_store (
    input  logic               clk_pixel,
    input  logic               recent_reset,
    pixel_stream_if.sink       in_i,
    input  blur_pkg::fb_addr_t rd_addr_i,
    output blur_pkg::rgb565_t  rd_data_o,
    output logic               frame_done_o
);

    blur_pkg::rgb565_t  mem [`FB_DEPTH];
    logic               accept;
    logic               keep;
    logic               last_beat;
    logic               last_seen;
    logic [31:0]        addr_calc;
    logic               wr_en;
    blur_pkg::fb_addr_t wr_addr;
    blur_pkg::rgb565_t  wr_data;

    assign in_i.ready = 1'b1;  // Buffer never stalls
    assign accept = in_i.valid && in_i.ready;

    // Keep one pixel out of every SCALE x SCALE block
    assign keep = accept && (in_i.hcount[`SCALE_SHIFT-1:0] == '0)
        && (in_i.vcount[`SCALE_SHIFT-1:0] == '0);
    assign last_beat = accept && (in_i.hcount == `HRES - 1) && (in_i.vcount == `VRES - 1);

    assign addr_calc = 32'(in_i.hcount >> `SCALE_SHIFT)
        + `FB_WIDTH * 32'(in_i.vcount >> `SCALE_SHIFT);

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= keep;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (keep) begin
            wr_addr <= blur_pkg::fb_addr_t'(addr_calc);
            wr_data <= in_i.pixel;
        end
    end

    // Write port and registered read port
    always_ff @(posedge clk_pixel) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data_o <= mem[rd_addr_i];
    end

    // Pulse lands one cycle behind the write slot of the last beat
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            last_seen    <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            last_seen    <= last_beat;
            frame_done_o <= last_seen;
        end
    end

    // Intake filtering has to keep every kept beat inside the buffer
    a_addr_range: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        keep |-> addr_calc < `FB_DEPTH)
        else $error("frame buffer write address out of range");

endmodule

// File: design/frame_intake.sv
`timescale 1ns/1ps
`include "blur_defs.svh"

module frame_intake (
    input  logic              clk_pixel,
    input  logic              recent_reset,
    input  logic              pixel_valid_i,
    output logic              pixel_ready_o,
    input  blur_pkg::rgb565_t pixel_data_i,
    input  blur_pkg::hcount_t hcount_i,
    input  blur_pkg::vcount_t vcount_i,
    pixel_stream_if.source    out_o
);

    logic accept;
    logic in_frame;

    assign pixel_ready_o = !out_o.valid || out_o.ready;  // Slot empty or draining now
    assign accept = pixel_valid_i && pixel_ready_o;
    assign in_frame = (hcount_i < `HRES) && (vcount_i < `VRES);

    // One-slot output register
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            out_o.valid <= 1'b0;
        end else if (accept) begin
            out_o.valid <= in_frame;  // Off-frame beats are swallowed here
        end else if (out_o.ready) begin
            out_o.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (accept && in_frame) begin
            out_o.pixel  <= pixel_data_i;
            out_o.hcount <= hcount_i;
            out_o.vcount <= vcount_i;
        end
    end

    // A refused input beat must be offered again unchanged
    a_stall_hold: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        pixel_valid_i && !pixel_ready_o |=> pixel_valid_i && $stable(pixel_data_i)
            && $stable(hcount_i) && $stable(vcount_i))
        else $error("pixel input changed while waiting for ready");

endmodule

// File: design/pixel_stream_if.sv
`timescale 1ns/1ps

// Valid/ready pixel stream with its coordinates alongside
interface pixel_stream_if;

    logic              valid;
    logic              ready;
    blur_pkg::rgb565_t pixel;
    blur_pkg::hcount_t hcount;
    blur_pkg::vcount_t vcount;

    // Beat moves on a clock edge with valid and ready both high
    modport source (
        output valid,
        output pixel,
        output hcount,
        output vcount,
        input  ready
    );

    modport sink (
        input  valid,
        input  pixel,
        input  hcount,
        input  vcount,
        output ready
    );

endinterface

// File: sim.f
+incdir+design
design/blur_pkg.sv
design/pixel_stream_if.sv
design/frame_intake.sv
design/blur_stage.sv
design/downscale_store.sv
design/blur_top.sv
bench/blur_tb.sv
